//--- hw/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

//////////////////////////////////////////////////
// Descriptor table
//////////////////////////////////////////////////

// Number of descriptor slots
`define DMA_TABLE_ENTRIES   4
// Entry index width, 7 at most (32-byte windows)
`define DMA_TABLE_PTR_WIDTH 2

//////////////////////////////////////////////////
// Bus and transfer widths
//////////////////////////////////////////////////

`define DMA_ADDR_WIDTH      32
`define DMA_DATA_WIDTH      32
// Transfer length in words
`define DMA_SIZE_WIDTH      8

// Requests the memory takes before a credit comes back
// Also the depth of the engine read buffer
`define DMA_MEM_CREDITS     2

`endif

//--- hw/dma_req_pkg.sv
`include "dma_params.svh"

package dma_req_pkg;

  // One programmed transfer
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] src_addr;
    logic [`DMA_ADDR_WIDTH-1:0] dst_addr;
    logic [`DMA_SIZE_WIDTH-1:0] size;
    logic                       irq_en;
  } dma_desc_t;

  // Descriptor word hit by a host access
  typedef enum logic [2:0] {
    FIELD_SRC,
    FIELD_DST,
    FIELD_SIZE,
    FIELD_CTRL,
    FIELD_STATUS,
    FIELD_NONE
  } dma_field_e;

  // Field write from decode to table
  typedef struct packed {
    logic [`DMA_TABLE_PTR_WIDTH-1:0] idx;
    dma_field_e                      field;
    logic [`DMA_DATA_WIDTH-1:0]      data;
  } dma_tbl_wr_t;

  // Launched entry handed to the copy engine
  typedef struct packed {
    logic [`DMA_TABLE_PTR_WIDTH-1:0] idx;
    dma_desc_t                       desc;
  } dma_issue_t;

  // Offset within the 32-byte entry window
  function automatic dma_field_e dma_field_decode(input logic [4:0] offset);
    case (offset)
      5'h00:   return FIELD_SRC;
      5'h04:   return FIELD_DST;
      5'h08:   return FIELD_SIZE;
      5'h0C:   return FIELD_CTRL;
      5'h14:   return FIELD_STATUS;
      default: return FIELD_NONE;
    endcase
  endfunction

endpackage

//--- hw/dma_mem_pkg.sv
`include "dma_params.svh"

package dma_mem_pkg;

  //////////////////////////////////////////////////
  // Memory port, one word per request
  //////////////////////////////////////////////////

  // Read when we is low, write of wdata when high
  typedef struct packed {
    logic                       we;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    logic [`DMA_DATA_WIDTH-1:0] wdata;
  } dma_mem_req_t;

  // Read data, strictly in request order
  // Writes return no response, only a credit
  typedef struct packed {
    logic                       valid;
    logic [`DMA_DATA_WIDTH-1:0] rdata;
  } dma_mem_rsp_t;

endpackage

//--- hw/dma_wb_decode.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_wb_decode
  import dma_req_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic [`DMA_ADDR_WIDTH-1:0]          wb_addr_i,
  input  logic [`DMA_DATA_WIDTH-1:0]          wb_dat_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  output logic [`DMA_DATA_WIDTH-1:0]          wb_dat_o,
  output logic                                wb_ack_o,
  // Addressed entry and table status
  input  dma_desc_t                           tbl_rdata_i,
  input  logic [`DMA_TABLE_ENTRIES-1:0]       done_i,
  input  logic [`DMA_TABLE_ENTRIES-1:0]       valid_i,
  // Strobes towards table and completion
  output dma_tbl_wr_t                         tbl_wr_o,
  output logic                                tbl_wr_valid_o,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]     rd_idx_o,
  output logic                                launch_valid_o,
  output logic                                clear_valid_o
);

  logic                            access;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] entry_idx;
  dma_field_e                      field;

  // Zero wait states so ack comes in the access cycle
  assign access   = wb_cyc_i & wb_stb_i;
  assign wb_ack_o = access;

  // Entry from bits 5 and up, field from the low five bits
  assign entry_idx = wb_addr_i[`DMA_TABLE_PTR_WIDTH+4:5];
  assign field     = dma_field_decode(wb_addr_i[4:0]);
  assign rd_idx_o  = entry_idx;

  //////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////

  assign tbl_wr_o = '{idx: entry_idx, field: field, data: wb_dat_i};
  // Only the four descriptor words go to the table
  assign tbl_wr_valid_o = access & wb_we_i &
                          (field != FIELD_STATUS) & (field != FIELD_NONE);

  // Status write bit 0 launches and bit 1 clears done
  assign launch_valid_o = access & wb_we_i & (field == FIELD_STATUS) & wb_dat_i[0];
  assign clear_valid_o  = access & wb_we_i & (field == FIELD_STATUS) & wb_dat_i[1];

  //////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////

  always_comb begin
    wb_dat_o = '0;
    case (field)
      FIELD_SRC:  wb_dat_o = tbl_rdata_i.src_addr;
      FIELD_DST:  wb_dat_o = tbl_rdata_i.dst_addr;
      FIELD_SIZE: wb_dat_o[`DMA_SIZE_WIDTH-1:0] = tbl_rdata_i.size;
      FIELD_CTRL: wb_dat_o[0] = tbl_rdata_i.irq_en;
      // Status as {valid, done}
      FIELD_STATUS: wb_dat_o[1:0] = {valid_i[entry_idx], done_i[entry_idx]};
      default: wb_dat_o = '0;
    endcase
  end

  // Host raises stb only inside a bus cycle
  a_stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb_i |-> wb_cyc_i);

endmodule

//--- hw/dma_req_table.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_req_table
  import dma_req_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n_i,
  // Host side
  input  dma_tbl_wr_t                         tbl_wr_i,
  input  logic                                tbl_wr_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     rd_idx_i,
  output dma_desc_t                           tbl_rdata_o,
  output logic [`DMA_TABLE_ENTRIES-1:0]       valid_o,
  output logic [`DMA_TABLE_ENTRIES-1:0]       irq_en_o,
  input  logic                                launch_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     launch_idx_i,
  // Engine side
  output dma_issue_t                          issue_o,
  output logic                                issue_valid_o,
  input  logic                                issue_ready_i,
  input  logic                                fin_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     fin_idx_i
);

  localparam int ENTRIES = `DMA_TABLE_ENTRIES;
  localparam int PTR_W   = `DMA_TABLE_PTR_WIDTH;

  dma_desc_t          desc_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  // Handed to the engine, not yet finished
  logic [ENTRIES-1:0] started_q;
  logic [PTR_W-1:0]   last_q;
  logic [PTR_W-1:0]   pick_idx;
  logic               pick_found;

  //////////////////////////////////////////////////
  // Descriptor storage
  //////////////////////////////////////////////////

  // Busy entries keep their fields
  always_ff @(posedge clk) begin
    if (tbl_wr_valid_i && !valid_q[tbl_wr_i.idx]) begin
      case (tbl_wr_i.field)
        FIELD_SRC:  desc_q[tbl_wr_i.idx].src_addr <= tbl_wr_i.data;
        FIELD_DST:  desc_q[tbl_wr_i.idx].dst_addr <= tbl_wr_i.data;
        FIELD_SIZE: desc_q[tbl_wr_i.idx].size <= tbl_wr_i.data[`DMA_SIZE_WIDTH-1:0];
        FIELD_CTRL: desc_q[tbl_wr_i.idx].irq_en <= tbl_wr_i.data[0];
        default: ;
      endcase
    end
  end

  assign tbl_rdata_o = desc_q[rd_idx_i];
  assign valid_o     = valid_q;

  for (genvar i = 0; i < ENTRIES; i++) begin : g_irq_en
    assign irq_en_o[i] = desc_q[i].irq_en;
  end

  //////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////

  // Search starts one past the last issued entry
  always_comb begin
    logic [PTR_W-1:0] cand;
    pick_found = 1'b0;
    pick_idx   = last_q;
    for (int k = 1; k <= ENTRIES; k++) begin
      cand = PTR_W'((int'(last_q) + k) % ENTRIES);
      if (!pick_found && valid_q[cand] && !started_q[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  assign issue_valid_o = pick_found;
  assign issue_o       = '{idx: pick_idx, desc: desc_q[pick_idx]};

  //////////////////////////////////////////////////
  // Entry state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q   <= '0;
      started_q <= '0;
      last_q    <= '0;
    end else begin
      // Relaunch of a live entry is ignored
      if (launch_valid_i && !valid_q[launch_idx_i]) begin
        valid_q[launch_idx_i]   <= 1'b1;
        started_q[launch_idx_i] <= 1'b0;
      end
      if (issue_valid_o && issue_ready_i) begin
        started_q[pick_idx] <= 1'b1;
        last_q              <= pick_idx;
      end
      if (fin_valid_i) begin
        valid_q[fin_idx_i]   <= 1'b0;
        started_q[fin_idx_i] <= 1'b0;
      end
    end
  end

  // Engine only finishes what it was given
  a_fin_started: assert property (@(posedge clk) disable iff (!rst_n_i)
    fin_valid_i |-> (valid_q[fin_idx_i] && started_q[fin_idx_i]));

endmodule

//--- hw/dma_copy_engine.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_copy_engine
  import dma_req_pkg::*;
  import dma_mem_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n_i,
  // From the table
  input  dma_issue_t                          issue_i,
  input  logic                                issue_valid_i,
  output logic                                issue_ready_o,
  // Memory port
  output dma_mem_req_t                        mem_req_o,
  output logic                                mem_req_valid_o,
  input  logic                                mem_credit_i,
  input  dma_mem_rsp_t                        mem_rsp_i,
  // Completion
  output logic                                fin_valid_o,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]     fin_idx_o
);

  localparam int CREDITS = `DMA_MEM_CREDITS;
  localparam int CRD_W   = $clog2(CREDITS + 1);
  localparam int BUF_W   = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int SIZE_W  = `DMA_SIZE_WIDTH;
  localparam int ADDR_W  = `DMA_ADDR_WIDTH;

  logic                            busy_q;
  dma_desc_t                       desc_q;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] idx_q;
  logic [SIZE_W-1:0]               rd_cnt_q;
  logic [SIZE_W-1:0]               wr_cnt_q;
  logic [CRD_W-1:0]                credit_q;
  // Read data waiting for its write
  logic [`DMA_DATA_WIDTH-1:0]      buf_q [CREDITS];
  logic [CRD_W-1:0]                buf_cnt_q;
  logic [BUF_W-1:0]                buf_head_q;
  logic [BUF_W-1:0]                buf_tail_q;

  logic              accept;
  logic [SIZE_W-1:0] pending;
  logic              send_rd;
  logic              send_wr;

  function automatic logic [BUF_W-1:0] buf_next(input logic [BUF_W-1:0] ptr);
    return (ptr == BUF_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign issue_ready_o = !busy_q;
  assign accept        = issue_valid_i && issue_ready_o;

  //////////////////////////////////////////////////
  // Request selection
  //////////////////////////////////////////////////

  // Reads in flight plus buffered words
  assign pending = rd_cnt_q - wr_cnt_q;

  // Writes first so the buffer always drains
  assign send_wr = busy_q && (credit_q != '0) && (buf_cnt_q != '0);
  // Reads bounded by free buffer slots
  assign send_rd = busy_q && (credit_q != '0) && !send_wr &&
                   (rd_cnt_q != desc_q.size) && (pending < SIZE_W'(CREDITS));

  assign mem_req_valid_o = send_wr || send_rd;

  always_comb begin
    mem_req_o.we    = send_wr;
    mem_req_o.wdata = buf_q[buf_head_q];
    // Word i at base + 4*i
    if (send_wr) begin
      mem_req_o.addr = desc_q.dst_addr + (ADDR_W'(wr_cnt_q) << 2);
    end else begin
      mem_req_o.addr = desc_q.src_addr + (ADDR_W'(rd_cnt_q) << 2);
    end
  end

  // Ends once the last write is sent or at once for size 0
  assign fin_valid_o = busy_q && (wr_cnt_q == desc_q.size);
  assign fin_idx_o   = idx_q;

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      desc_q <= issue_i.desc;
      idx_q  <= issue_i.idx;
    end
    if (mem_rsp_i.valid) begin
      buf_q[buf_tail_q] <= mem_rsp_i.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      rd_cnt_q   <= '0;
      wr_cnt_q   <= '0;
      credit_q   <= CRD_W'(CREDITS);
      buf_cnt_q  <= '0;
      buf_head_q <= '0;
      buf_tail_q <= '0;
    end else begin
      if (accept) begin
        busy_q   <= 1'b1;
        rd_cnt_q <= '0;
        wr_cnt_q <= '0;
      end else begin
        if (fin_valid_o) begin
          busy_q <= 1'b0;
        end
        if (send_rd) begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
        end
        if (send_wr) begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
        end
      end
      // Buffer pops on a write and pushes on a response
      if (send_wr) begin
        buf_head_q <= buf_next(buf_head_q);
      end
      if (mem_rsp_i.valid) begin
        buf_tail_q <= buf_next(buf_tail_q);
      end
      buf_cnt_q <= buf_cnt_q + CRD_W'(mem_rsp_i.valid) - CRD_W'(send_wr);
      // One credit spent per send and one back per consumed request
      credit_q  <= credit_q + CRD_W'(mem_credit_i) - CRD_W'(mem_req_valid_o);
    end
  end

  // Memory never hands back more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
    credit_q <= CRD_W'(CREDITS));

  // Read data only comes back for reads still in flight
  a_rsp_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_rsp_i.valid |-> (SIZE_W'(buf_cnt_q) < pending));

endmodule

//--- hw/dma_completion.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_completion (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                fin_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     fin_idx_i,
  input  logic                                launch_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     launch_idx_i,
  input  logic                                clear_valid_i,
  input  logic [`DMA_TABLE_PTR_WIDTH-1:0]     clear_idx_i,
  input  logic [`DMA_TABLE_ENTRIES-1:0]       irq_en_i,
  output logic [`DMA_TABLE_ENTRIES-1:0]       done_o,
  output logic                                irq_o
);

  logic [`DMA_TABLE_ENTRIES-1:0] done_q;
  logic [`DMA_TABLE_ENTRIES-1:0] done_d;
  logic                          irq_q;

  //////////////////////////////////////////////////
  // Done bits
  //////////////////////////////////////////////////

  always_comb begin
    done_d = done_q;
    // Fresh launch starts undone
    if (launch_valid_i) begin
      done_d[launch_idx_i] = 1'b0;
    end
    // Host acknowledge
    if (clear_valid_i) begin
      done_d[clear_idx_i] = 1'b0;
    end
    // Finish wins over a same-cycle clear
    if (fin_valid_i) begin
      done_d[fin_idx_i] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      done_q <= '0;
      irq_q  <= 1'b0;
    end else begin
      done_q <= done_d;
      // Rises together with the done bit
      irq_q  <= |(done_d & irq_en_i);
    end
  end

  assign done_o = done_q;
  assign irq_o  = irq_q;

endmodule

//--- hw/dma_tile.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_tile
  import dma_req_pkg::*;
  import dma_mem_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Host port
  input  logic [`DMA_ADDR_WIDTH-1:0] wb_addr_i,
  input  logic [`DMA_DATA_WIDTH-1:0] wb_dat_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  output logic [`DMA_DATA_WIDTH-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  // Memory port
  output dma_mem_req_t               mem_req_o,
  output logic                       mem_req_valid_o,
  input  logic                       mem_credit_i,
  input  dma_mem_rsp_t               mem_rsp_i,
  output logic                       irq_o
);

  dma_tbl_wr_t                     tbl_wr;
  logic                            tbl_wr_valid;
  dma_desc_t                       tbl_rdata;
  // Addressed entry, also the launch and clear index
  logic [`DMA_TABLE_PTR_WIDTH-1:0] host_idx;
  logic                            launch_valid;
  logic                            clear_valid;
  logic [`DMA_TABLE_ENTRIES-1:0]   valid_vec;
  logic [`DMA_TABLE_ENTRIES-1:0]   done_vec;
  logic [`DMA_TABLE_ENTRIES-1:0]   irq_en_vec;
  dma_issue_t                      issue;
  logic                            issue_valid;
  logic                            issue_ready;
  logic                            fin_valid;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] fin_idx;

  dma_wb_decode u_decode (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .tbl_rdata_i    (tbl_rdata),
    .done_i         (done_vec),
    .valid_i        (valid_vec),
    .tbl_wr_o       (tbl_wr),
    .tbl_wr_valid_o (tbl_wr_valid),
    .rd_idx_o       (host_idx),
    .launch_valid_o (launch_valid),
    .clear_valid_o  (clear_valid)
  );

  dma_req_table u_table (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .tbl_wr_i       (tbl_wr),
    .tbl_wr_valid_i (tbl_wr_valid),
    .rd_idx_i       (host_idx),
    .tbl_rdata_o    (tbl_rdata),
    .valid_o        (valid_vec),
    .irq_en_o       (irq_en_vec),
    .launch_valid_i (launch_valid),
    .launch_idx_i   (host_idx),
    .issue_o        (issue),
    .issue_valid_o  (issue_valid),
    .issue_ready_i  (issue_ready),
    .fin_valid_i    (fin_valid),
    .fin_idx_i      (fin_idx)
  );

  dma_copy_engine u_engine (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .issue_i         (issue),
    .issue_valid_i   (issue_valid),
    .issue_ready_o   (issue_ready),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_credit_i    (mem_credit_i),
    .mem_rsp_i       (mem_rsp_i),
    .fin_valid_o     (fin_valid),
    .fin_idx_o       (fin_idx)
  );

  dma_completion u_completion (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .fin_valid_i    (fin_valid),
    .fin_idx_i      (fin_idx),
    .launch_valid_i (launch_valid),
    .launch_idx_i   (host_idx),
    .clear_valid_i  (clear_valid),
    .clear_idx_i    (host_idx),
    .irq_en_i       (irq_en_vec),
    .done_o         (done_vec),
    .irq_o          (irq_o)
  );

endmodule

//--- bench/dma_mem_model.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_mem_model
  import dma_mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  dma_mem_req_t mem_req_i,
  input  logic         mem_req_valid_i,
  output logic         mem_credit_o,
  output dma_mem_rsp_t mem_rsp_o,
  output logic         overflow_o,
  output int           write_cnt_o
);

  // 4 KB of word storage, addresses alias above that
  localparam int WORDS = 1024;

  logic [31:0] mem [WORDS];
  // Accepted requests waiting for their credit, oldest first
  logic        pend_rd_q   [$];
  logic [31:0] pend_data_q [$];
  int          pend_due_q  [$];
  int          cycle;
  int          last_due;
  integer      seed = 32'h82570b5c;

  initial begin
    cycle        = 0;
    last_due     = 0;
    overflow_o   = 1'b0;
    write_cnt_o  = 0;
    mem_credit_o = 1'b0;
    mem_rsp_o    = '0;
    // Each word holds its own byte address XOR a fixed mask
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (32'(i) << 2) ^ 32'hA5A50000;
    end
  end

  //////////////////////////////////////////////////
  // Request intake and in-order retirement
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    logic        fire;
    logic        fire_rd;
    logic [31:0] fire_data;
    int          due;
    fire      = 1'b0;
    fire_rd   = 1'b0;
    fire_data = '0;
    if (!rst_n_i) begin
      pend_rd_q.delete();
      pend_data_q.delete();
      pend_due_q.delete();
      last_due    = cycle;
      overflow_o  = 1'b0;
      write_cnt_o = 0;
    end else begin
      cycle = cycle + 1;
      if (mem_req_valid_i) begin
        // 1 to 4 cycles, never ahead of an older request
        due = cycle + 1 + int'($unsigned($random(seed)) % 4);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_due_q.push_back(due);
        pend_rd_q.push_back(!mem_req_i.we);
        // Data moves at acceptance, only credit and response wait
        if (mem_req_i.we) begin
          mem[mem_req_i.addr[11:2]] = mem_req_i.wdata;
          write_cnt_o = write_cnt_o + 1;
          pend_data_q.push_back('0);
        end else begin
          pend_data_q.push_back(mem[mem_req_i.addr[11:2]]);
        end
        if (pend_due_q.size() > `DMA_MEM_CREDITS) begin
          overflow_o = 1'b1;
        end
      end
      if (pend_due_q.size() > 0 && pend_due_q[0] <= cycle) begin
        fire      = 1'b1;
        fire_rd   = pend_rd_q.pop_front();
        fire_data = pend_data_q.pop_front();
        void'(pend_due_q.pop_front());
      end
    end
    #1;
    mem_credit_o    = fire;
    mem_rsp_o.valid = fire & fire_rd;
    mem_rsp_o.rdata = fire_data;
  end

endmodule

//--- bench/dma_tile_tb.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dma_tile_tb
  import dma_mem_pkg::*;
();

  localparam int          NROWS      = 7;
  localparam int          ENTRIES    = `DMA_TABLE_ENTRIES;
  localparam logic [31:0] FILL_MASK  = 32'hA5A50000;
  // Register offsets inside an entry window
  localparam logic [4:0]  OFS_SRC    = 5'h00;
  localparam logic [4:0]  OFS_DST    = 5'h04;
  localparam logic [4:0]  OFS_SIZE   = 5'h08;
  localparam logic [4:0]  OFS_CTRL   = 5'h0C;
  localparam logic [4:0]  OFS_STATUS = 5'h14;

  typedef struct packed {
    logic [`DMA_TABLE_PTR_WIDTH-1:0] entry;
    logic [31:0]                     src;
    logic [31:0]                     dst;
    logic [7:0]                      size;
    logic                            irq_en;
    // Launched in the same burst as the row before
    logic                            b2b;
    // Overwrite and relaunch tried while busy
    logic                            probe;
  } row_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic [31:0]  wb_addr;
  logic [31:0]  wb_wdata;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  logic [31:0]  wb_rdata;
  logic         wb_ack;
  dma_mem_req_t mem_req;
  logic         mem_req_valid;
  logic         mem_credit;
  dma_mem_rsp_t mem_rsp;
  logic         irq;
  logic         mem_overflow;
  int           mem_writes;

  row_t                 rows [NROWS];
  logic [ENTRIES-1:0]   done_exp;
  logic [ENTRIES-1:0]   irq_en_exp;
  int                   err_count;
  int                   test_count;
  int                   test_fail;
  int                   test_err_start;
  string                test_name;
  int                   cycle_count;
  int                   timeout_limit;

  dma_tile u_dma_tile (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .wb_addr_i       (wb_addr),
    .wb_dat_i        (wb_wdata),
    .wb_cyc_i        (wb_cyc),
    .wb_stb_i        (wb_stb),
    .wb_we_i         (wb_we),
    .wb_dat_o        (wb_rdata),
    .wb_ack_o        (wb_ack),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_credit_i    (mem_credit),
    .mem_rsp_i       (mem_rsp),
    .irq_o           (irq)
  );

  dma_mem_model u_mem (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .mem_req_i       (mem_req),
    .mem_req_valid_i (mem_req_valid),
    .mem_credit_o    (mem_credit),
    .mem_rsp_o       (mem_rsp),
    .overflow_o      (mem_overflow),
    .write_cnt_o     (mem_writes)
  );

  always #5 clk = ~clk;

  // Cycle budget from the stimulus table
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Run timed out after %0d cycles, DMA never finished", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      err_count = err_count + 1;
    end
  endtask

  // Memory preload rule
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ FILL_MASK;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return u_mem.mem[addr[11:2]];
  endfunction

  function automatic logic [31:0] reg_addr(input logic [`DMA_TABLE_PTR_WIDTH-1:0] entry,
                                           input logic [4:0] ofs);
    return 32'({entry, ofs});
  endfunction

  function automatic row_t make_row(input int entry, input logic [31:0] src,
                                    input logic [31:0] dst, input int size,
                                    input bit irq_en, input bit b2b, input bit probe);
    row_t row;
    row.entry  = entry[`DMA_TABLE_PTR_WIDTH-1:0];
    row.src    = src;
    row.dst    = dst;
    row.size   = size[7:0];
    row.irq_en = irq_en;
    row.b2b    = b2b;
    row.probe  = probe;
    return row;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic bus_cycle(input logic we, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    wb_addr  = addr;
    wb_wdata = wdata;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    // Ack and read data settled mid-cycle
    @(negedge clk);
    check_value("wb_ack_o", 32'(wb_ack), 32'h1);
    rdata = wb_rdata;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
    bus_cycle(1'b0, addr, 32'h0, data);
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_count;
  endtask

  task automatic end_test();
    int errs;
    errs       = err_count - test_err_start;
    test_count = test_count + 1;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_count, test_name);
    end else begin
      test_fail = test_fail + 1;
      $display("test %0d %s: FAIL with %0d errors", test_count, test_name, errs);
    end
  endtask

  // Interrupt is the OR of done and irq_en
  task automatic check_irq();
    check_value("irq_o", 32'(irq), 32'(|(done_exp & irq_en_exp)));
  endtask

  //////////////////////////////////////////////////
  // Per-row steps
  //////////////////////////////////////////////////

  task automatic program_row(input row_t row);
    logic [31:0] rd;
    wb_write(reg_addr(row.entry, OFS_SRC), row.src);
    wb_write(reg_addr(row.entry, OFS_DST), row.dst);
    wb_write(reg_addr(row.entry, OFS_SIZE), 32'(row.size));
    wb_write(reg_addr(row.entry, OFS_CTRL), 32'(row.irq_en));
    irq_en_exp[row.entry] = row.irq_en;
    wb_read(reg_addr(row.entry, OFS_SRC), rd);
    check_value("wb_dat_o src", rd, row.src);
    wb_read(reg_addr(row.entry, OFS_DST), rd);
    check_value("wb_dat_o dst", rd, row.dst);
    wb_read(reg_addr(row.entry, OFS_SIZE), rd);
    check_value("wb_dat_o size", rd, 32'(row.size));
    wb_read(reg_addr(row.entry, OFS_CTRL), rd);
    check_value("wb_dat_o ctrl", rd, 32'(row.irq_en));
  endtask

  // Busy entry keeps its fields and ignores a relaunch
  task automatic probe_busy(input row_t row);
    logic [31:0] rd;
    wb_read(reg_addr(row.entry, OFS_STATUS), rd);
    check_value("status valid", 32'(rd[1]), 32'h1);
    wb_write(reg_addr(row.entry, OFS_SRC), ~row.src);
    wb_read(reg_addr(row.entry, OFS_SRC), rd);
    check_value("wb_dat_o src busy", rd, row.src);
    wb_write(reg_addr(row.entry, OFS_STATUS), 32'h1);
  endtask

  task automatic wait_done(input logic [`DMA_TABLE_PTR_WIDTH-1:0] entry);
    logic [31:0] rd;
    rd = '0;
    while (rd[0] !== 1'b1) begin
      wb_read(reg_addr(entry, OFS_STATUS), rd);
    end
  endtask

  task automatic check_copy(input row_t row);
    logic [31:0] addr;
    int          i;
    for (i = 0; i < row.size; i++) begin
      addr = row.dst + 32'(4 * i);
      check_value($sformatf("mem[%h]", addr), mem_word(addr), fill_word(row.src + 32'(4 * i)));
    end
    // First word past the block stays at its fill value
    addr = row.dst + 32'(4 * row.size);
    check_value($sformatf("mem[%h]", addr), mem_word(addr), fill_word(addr));
  endtask

  task automatic run_group(input int first, input int last);
    logic [31:0] rd;
    int          r;
    int          writes_before;
    int          writes_exp;
    writes_before = mem_writes;
    writes_exp    = 0;
    // Launches on consecutive cycles
    for (r = first; r <= last; r++) begin
      wb_write(reg_addr(rows[r].entry, OFS_STATUS), 32'h1);
      done_exp[rows[r].entry] = 1'b0;
      writes_exp = writes_exp + rows[r].size;
    end
    for (r = first; r <= last; r++) begin
      if (rows[r].probe) begin
        probe_busy(rows[r]);
      end
    end
    for (r = first; r <= last; r++) begin
      wait_done(rows[r].entry);
      done_exp[rows[r].entry] = 1'b1;
    end
    for (r = first; r <= last; r++) begin
      wb_read(reg_addr(rows[r].entry, OFS_STATUS), rd);
      check_value("status", rd, 32'h1);
      check_copy(rows[r]);
    end
    // No extra or repeated writes, credits respected
    check_value("mem writes", 32'(mem_writes - writes_before), 32'(writes_exp));
    check_value("mem overflow", 32'(mem_overflow), 32'h0);
    check_irq();
    for (r = first; r <= last; r++) begin
      wb_write(reg_addr(rows[r].entry, OFS_STATUS), 32'h2);
      done_exp[rows[r].entry] = 1'b0;
      check_irq();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    int          r;
    int          e;
    int          group_start;
    rst_n          = 1'b0;
    wb_addr        = '0;
    wb_wdata       = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    done_exp       = '0;
    irq_en_exp     = '0;
    err_count      = 0;
    test_count     = 0;
    test_fail      = 0;
    cycle_count    = 0;
    // entry, src, dst, size, irq_en, b2b, probe
    rows[0] = make_row(0, 32'h100, 32'h800, 6, 1'b0, 1'b0, 1'b0);
    rows[1] = make_row(1, 32'h040, 32'h880, 0, 1'b1, 1'b0, 1'b0);
    rows[2] = make_row(0, 32'h200, 32'h900, 5, 1'b1, 1'b0, 1'b0);
    rows[3] = make_row(1, 32'h240, 32'h940, 3, 1'b0, 1'b1, 1'b0);
    rows[4] = make_row(2, 32'h280, 32'h980, 8, 1'b1, 1'b1, 1'b0);
    rows[5] = make_row(3, 32'h2C0, 32'h9C0, 4, 1'b0, 1'b1, 1'b0);
    rows[6] = make_row(2, 32'h300, 32'hA00, 12, 1'b0, 1'b0, 1'b1);
    timeout_limit = 0;
    for (r = 0; r < NROWS; r++) begin
      timeout_limit = timeout_limit + 12 * rows[r].size + 100;
    end

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset state");
    for (e = 0; e < ENTRIES; e++) begin
      wb_read(reg_addr(e[`DMA_TABLE_PTR_WIDTH-1:0], OFS_STATUS), rd);
      check_value("status", rd, 32'h0);
    end
    check_value("irq_o", 32'(irq), 32'h0);
    check_value("mem_req_valid_o", 32'(mem_req_valid), 32'h0);
    end_test();

    // A group is a row plus the b2b rows after it
    group_start = 0;
    for (r = 0; r < NROWS; r++) begin
      if (!rows[r].b2b) begin
        group_start = r;
        start_test($sformatf("copy group from row %0d", r));
      end
      program_row(rows[r]);
      if (r == NROWS - 1 || !rows[r + 1].b2b) begin
        run_group(group_start, r);
        end_test();
      end
    end

    $display("%0d tests run, %0d failing, %0d errors", test_count, test_fail, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+hw
hw/dma_req_pkg.sv
hw/dma_mem_pkg.sv
hw/dma_wb_decode.sv
hw/dma_req_table.sv
hw/dma_copy_engine.sv
hw/dma_completion.sv
hw/dma_tile.sv
bench/dma_mem_model.sv
bench/dma_tile_tb.sv
